// File: logic/cnfg_pkg.sv
/* Register map, widths, field positions and struct types
   shared by the host control-register block */
package cnfg_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int AXIL_DATA_BITS    = 64;
  localparam int AXIL_ADDR_BITS    = 10;
  localparam int ADDR_LSB          = 3;   // Byte offset inside a register
  localparam int REG_IDX_BITS      = 7;   // 128 registers
  localparam int PADDR_BITS        = 48;
  localparam int LEN_BITS          = 28;
  localparam int WB_DATA_BITS      = 32;  // Writeback value width
  localparam int LOWSPEED_OUT_BITS = 3;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  localparam logic [REG_IDX_BITS-1:0] PROBE_REG    = 7'd0;
  localparam logic [REG_IDX_BITS-1:0] N_CHAN_REG   = 7'd1;
  localparam logic [REG_IDX_BITS-1:0] LOWSPEED_REG = 7'd8;
  localparam logic [REG_IDX_BITS-1:0] PR_CTRL_REG  = 7'd10;  // Self-clearing
  localparam logic [REG_IDX_BITS-1:0] PR_STAT_REG  = 7'd11;
  localparam logic [REG_IDX_BITS-1:0] PR_ADDR_REG  = 7'd12;
  localparam logic [REG_IDX_BITS-1:0] PR_LEN_REG   = 7'd13;

  // Control and status bits
  localparam int PR_START = 0;
  localparam int PR_CTL   = 1;
  localparam int PR_CLR   = 2;
  localparam int PR_DONE  = 0;
  localparam int PR_READY = 1;

  localparam int LOWSPEED_BITS = 6;
  localparam logic [LOWSPEED_BITS-1:0] LOWSPEED_RESET = '1;

  // Read-only configuration words
  localparam logic [31:0] PROBE_ID = 32'h6b1c_0e93;
  localparam logic [7:0]  N_CHAN   = 8'd4;

  // Queues and writeback
  localparam int PR_QDEPTH = 16;
  localparam int WB_QDEPTH = 4;
  localparam logic [LEN_BITS-1:0] WB_LEN = 28'd4;  // One 32-bit value

  // --------------------------------------------------
  // Struct types
  // --------------------------------------------------
  typedef struct packed {
    logic [AXIL_ADDR_BITS-1:0]   awaddr;
    logic                        awvalid;
    logic [AXIL_DATA_BITS-1:0]   wdata;
    logic [AXIL_DATA_BITS/8-1:0] wstrb;
    logic                        wvalid;
    logic                        bready;
    logic [AXIL_ADDR_BITS-1:0]   araddr;
    logic                        arvalid;
    logic                        rready;
  } axil_m2s_t;

  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    logic [1:0]                bresp;
    logic                      arready;
    logic                      rvalid;
    logic [AXIL_DATA_BITS-1:0] rdata;
    logic [1:0]                rresp;
  } axil_s2m_t;

  typedef struct packed {
    logic [REG_IDX_BITS-1:0]     idx;
    logic [AXIL_DATA_BITS-1:0]   data;
    logic [AXIL_DATA_BITS/8-1:0] strb;
  } reg_wr_t;

  typedef struct packed {
    logic                  ctl;
    logic [PADDR_BITS-1:0] paddr;
    logic [LEN_BITS-1:0]   len;
  } dma_req_t;

  typedef struct packed {
    logic [PADDR_BITS-1:0]   paddr;
    logic [WB_DATA_BITS-1:0] value;
  } wback_t;

endpackage

// File: logic/req_queue.sv
/* Circular-buffer FIFO with occupancy count, registered output
   and valid/ready on both sides */
`timescale 1ns/1ps

module req_queue #(
  parameter type QTYPE  = logic [31:0],
  parameter int  QDEPTH = 4
) (
  input  logic aclk,
  input  logic aresetn,
  input  QTYPE snk_data,
  input  logic snk_valid,
  output logic snk_ready,
  output QTYPE src_data,
  output logic src_valid,
  input  logic src_ready
);

  localparam int PTR_BITS = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
  localparam int CNT_BITS = $clog2(QDEPTH + 1);

  QTYPE mem [QDEPTH];
  QTYPE src_data_q;

  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [CNT_BITS-1:0] count_q;   // Entries in memory plus output stage
  logic                src_valid_q;

  logic push;
  logic pop;
  logic load;

  logic [CNT_BITS-1:0] mem_used;  // Entries waiting in memory
  logic [PTR_BITS:0]   ptr_dist;

  assign snk_ready = (count_q < CNT_BITS'(QDEPTH));
  assign push = snk_valid && snk_ready;
  assign pop  = src_valid_q && src_ready;
  assign mem_used = count_q - CNT_BITS'(src_valid_q);
  assign load = (mem_used != '0) && (!src_valid_q || src_ready);

  // Distance from read to write pointer, wrapping at the depth
  assign ptr_dist = (wr_ptr_q >= rd_ptr_q) ?
                    ({1'b0, wr_ptr_q} - {1'b0, rd_ptr_q}) :
                    ({1'b0, wr_ptr_q} + (PTR_BITS+1)'(QDEPTH) - {1'b0, rd_ptr_q});

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      src_valid_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_BITS'(QDEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (load) begin
        rd_ptr_q <= (rd_ptr_q == PTR_BITS'(QDEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_BITS'(push) - CNT_BITS'(pop);

      if (load) begin
        src_valid_q <= 1'b1;
      end else if (pop) begin
        src_valid_q <= 1'b0;
      end
    end
  end

  // Storage and output stage
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr_q] <= snk_data;
    end
    if (load) begin
      src_data_q <= mem[rd_ptr_q];
    end
  end

  assign src_data  = src_data_q;
  assign src_valid = src_valid_q;

  // A push never lands on an entry still waiting in memory
  a_no_overrun: assert property (@(posedge aclk) disable iff (!aresetn)
    (mem_used == CNT_BITS'(QDEPTH)) ? (ptr_dist == '0)
                                    : (CNT_BITS'(ptr_dist) == mem_used));

endmodule

// File: logic/axil_ctrl_port.sv
/* AXI4-Lite slave handshake, turns bus writes and reads into
   register write commands and register index lookups */
`timescale 1ns/1ps

module axil_ctrl_port (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  cnfg_pkg::axil_m2s_t                 s_axil,
  output cnfg_pkg::axil_s2m_t                 s_axil_rsp,
  output cnfg_pkg::reg_wr_t                   reg_wr,
  output logic                                reg_wr_en,
  output logic [cnfg_pkg::REG_IDX_BITS-1:0]   rd_idx,
  input  logic [cnfg_pkg::AXIL_DATA_BITS-1:0] rd_data
);

  logic aw_en_q;  // No write response outstanding
  logic awready_q;
  logic wready_q;
  logic bvalid_q;
  logic arready_q;
  logic rvalid_q;

  logic [cnfg_pkg::REG_IDX_BITS-1:0]   wr_idx_q;
  logic [cnfg_pkg::REG_IDX_BITS-1:0]   rd_idx_q;
  logic [cnfg_pkg::AXIL_DATA_BITS-1:0] rdata_q;

  logic aw_accept;
  logic ar_accept;
  logic wr_hs;
  logic rd_hs;

  assign aw_accept = !awready_q && s_axil.awvalid && s_axil.wvalid && aw_en_q;
  assign ar_accept = !arready_q && s_axil.arvalid && !rvalid_q;
  assign wr_hs = awready_q && s_axil.awvalid && wready_q && s_axil.wvalid;
  assign rd_hs = arready_q && s_axil.arvalid && !rvalid_q;

  // --------------------------------------------------
  // Handshake state
  // --------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      aw_en_q   <= 1'b1;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      awready_q <= aw_accept;  // One-cycle pulses
      wready_q  <= aw_accept;
      arready_q <= ar_accept;

      if (aw_accept) begin
        aw_en_q <= 1'b0;
      end else if (bvalid_q && s_axil.bready) begin
        aw_en_q <= 1'b1;
      end

      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (s_axil.bready) begin
        bvalid_q <= 1'b0;
      end

      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (s_axil.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Latched indices and read data
  always_ff @(posedge aclk) begin
    if (aw_accept) begin
      wr_idx_q <= s_axil.awaddr[cnfg_pkg::ADDR_LSB +: cnfg_pkg::REG_IDX_BITS];
    end
    if (ar_accept) begin
      rd_idx_q <= s_axil.araddr[cnfg_pkg::ADDR_LSB +: cnfg_pkg::REG_IDX_BITS];
    end
    if (rd_hs) begin
      rdata_q <= rd_data;
    end
  end

  // --------------------------------------------------
  // Register file side
  // --------------------------------------------------
  always_comb begin
    reg_wr.idx  = wr_idx_q;
    reg_wr.data = s_axil.wdata;  // Held stable by the master until wready
    reg_wr.strb = s_axil.wstrb;
  end

  assign reg_wr_en = wr_hs;
  assign rd_idx    = rd_idx_q;

  always_comb begin
    s_axil_rsp.awready = awready_q;
    s_axil_rsp.wready  = wready_q;
    s_axil_rsp.bvalid  = bvalid_q;
    s_axil_rsp.bresp   = cnfg_pkg::RESP_OKAY;
    s_axil_rsp.arready = arready_q;
    s_axil_rsp.rvalid  = rvalid_q;
    s_axil_rsp.rdata   = rdata_q;
    s_axil_rsp.rresp   = cnfg_pkg::RESP_OKAY;
  end

  // Responses hold until taken
  a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    (bvalid_q && !s_axil.bready) |=> bvalid_q);

  a_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    (rvalid_q && !s_axil.rready) |=> (rvalid_q && $stable(rdata_q)));

endmodule

// File: logic/cnfg_regs.sv
/* Register file with write decode, read mux, PR control and
   status, and the PR DMA request queue */
`timescale 1ns/1ps

module cnfg_regs (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  cnfg_pkg::reg_wr_t                      reg_wr,
  input  logic                                   reg_wr_en,
  input  logic [cnfg_pkg::REG_IDX_BITS-1:0]      rd_idx,
  output logic [cnfg_pkg::AXIL_DATA_BITS-1:0]    rd_data,
  output cnfg_pkg::dma_req_t                     m_pr_dma,
  output logic                                   m_pr_dma_valid,
  input  logic                                   m_pr_dma_ready,
  input  logic                                   pr_dma_done,
  output logic [cnfg_pkg::LOWSPEED_OUT_BITS-1:0] lowspeed_ctrl
);

  localparam int STRB_BITS = cnfg_pkg::AXIL_DATA_BITS / 8;

  logic [cnfg_pkg::LOWSPEED_BITS-1:0]  lowspeed_q;
  logic [15:0]                         pr_ctrl_q;
  logic                                pr_done_q;
  logic [cnfg_pkg::AXIL_DATA_BITS-1:0] pr_addr_q;
  logic [31:0]                         pr_len_q;

  cnfg_pkg::dma_req_t pr_req;
  logic               pr_ready;  // PR queue has room

  // --------------------------------------------------
  // Write decode
  // --------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      lowspeed_q <= cnfg_pkg::LOWSPEED_RESET;
      pr_ctrl_q  <= '0;
      pr_done_q  <= 1'b0;
      pr_addr_q  <= '0;
      pr_len_q   <= '0;
    end else begin
      pr_ctrl_q <= '0;  // Strobes last one cycle

      // Clear beats a done arriving in the same cycle
      if (pr_ctrl_q[cnfg_pkg::PR_CLR]) begin
        pr_done_q <= 1'b0;
      end else if (pr_dma_done) begin
        pr_done_q <= 1'b1;
      end

      if (reg_wr_en) begin
        case (reg_wr.idx)
          cnfg_pkg::LOWSPEED_REG: begin
            if (reg_wr.strb[0]) begin
              lowspeed_q <= reg_wr.data[cnfg_pkg::LOWSPEED_BITS-1:0];
            end
          end
          cnfg_pkg::PR_CTRL_REG: begin
            for (int i = 0; i < 2; i++) begin
              if (reg_wr.strb[i]) begin
                pr_ctrl_q[i*8 +: 8] <= reg_wr.data[i*8 +: 8];
              end
            end
          end
          cnfg_pkg::PR_ADDR_REG: begin
            for (int i = 0; i < STRB_BITS; i++) begin
              if (reg_wr.strb[i]) begin
                pr_addr_q[i*8 +: 8] <= reg_wr.data[i*8 +: 8];
              end
            end
          end
          cnfg_pkg::PR_LEN_REG: begin
            for (int i = 0; i < 4; i++) begin
              if (reg_wr.strb[i]) begin
                pr_len_q[i*8 +: 8] <= reg_wr.data[i*8 +: 8];
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    rd_data = '0;  // Unmapped reads return zero
    case (rd_idx)
      cnfg_pkg::PROBE_REG:    rd_data[31:0] = cnfg_pkg::PROBE_ID;
      cnfg_pkg::N_CHAN_REG:   rd_data[7:0] = cnfg_pkg::N_CHAN;
      cnfg_pkg::LOWSPEED_REG: rd_data[cnfg_pkg::LOWSPEED_BITS-1:0] = lowspeed_q;
      cnfg_pkg::PR_STAT_REG: begin
        rd_data[cnfg_pkg::PR_READY] = pr_ready;
        rd_data[cnfg_pkg::PR_DONE]  = pr_done_q;
      end
      cnfg_pkg::PR_ADDR_REG:  rd_data = pr_addr_q;
      cnfg_pkg::PR_LEN_REG:   rd_data[31:0] = pr_len_q;
      default: ;
    endcase
  end

  assign lowspeed_ctrl = lowspeed_q[cnfg_pkg::LOWSPEED_OUT_BITS-1:0];

  // --------------------------------------------------
  // PR request queue
  // --------------------------------------------------
  always_comb begin
    pr_req.ctl   = pr_ctrl_q[cnfg_pkg::PR_CTL];
    pr_req.paddr = pr_addr_q[cnfg_pkg::PADDR_BITS-1:0];
    pr_req.len   = pr_len_q[cnfg_pkg::LEN_BITS-1:0];
  end

  // A start into a full queue is dropped
  req_queue #(
    .QTYPE  (cnfg_pkg::dma_req_t),
    .QDEPTH (cnfg_pkg::PR_QDEPTH)
  ) pr_queue_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .snk_data  (pr_req),
    .snk_valid (pr_ctrl_q[cnfg_pkg::PR_START]),
    .snk_ready (pr_ready),
    .src_data  (m_pr_dma),
    .src_valid (m_pr_dma_valid),
    .src_ready (m_pr_dma_ready)
  );

endmodule

// File: logic/wback_path.sv
/* Writeback path, splits each item into a DMA write request
   and a 32-bit value stream, each through its own queue */
`timescale 1ns/1ps

module wback_path (
  input  logic                              aclk,
  input  logic                              aresetn,
  input  cnfg_pkg::wback_t                  s_wback,
  input  logic                              s_wback_valid,
  output logic                              s_wback_ready,
  output cnfg_pkg::dma_req_t                m_wb_dma,
  output logic                              m_wb_dma_valid,
  input  logic                              m_wb_dma_ready,
  output logic [cnfg_pkg::WB_DATA_BITS-1:0] m_axis_wb_tdata,
  output logic                              m_axis_wb_tvalid,
  input  logic                              m_axis_wb_tready
);

  cnfg_pkg::dma_req_t wb_req;
  logic               req_ready;
  logic               val_ready;
  logic               push;

  always_comb begin
    wb_req.ctl   = 1'b1;  // Write direction
    wb_req.paddr = s_wback.paddr;
    wb_req.len   = cnfg_pkg::WB_LEN;
  end

  // Both queues take the item together or not at all
  assign s_wback_ready = req_ready && val_ready;
  assign push = s_wback_valid && s_wback_ready;

  req_queue #(
    .QTYPE  (cnfg_pkg::dma_req_t),
    .QDEPTH (cnfg_pkg::WB_QDEPTH)
  ) wb_req_queue_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .snk_data  (wb_req),
    .snk_valid (push),
    .snk_ready (req_ready),
    .src_data  (m_wb_dma),
    .src_valid (m_wb_dma_valid),
    .src_ready (m_wb_dma_ready)
  );

  req_queue #(
    .QTYPE  (logic [cnfg_pkg::WB_DATA_BITS-1:0]),
    .QDEPTH (cnfg_pkg::WB_QDEPTH)
  ) wb_val_queue_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .snk_data  (s_wback.value),
    .snk_valid (push),
    .snk_ready (val_ready),
    .src_data  (m_axis_wb_tdata),
    .src_valid (m_axis_wb_tvalid),
    .src_ready (m_axis_wb_tready)
  );

endmodule

// File: logic/cnfg_slave.sv
/* Host control-register block top, bus port, register file
   and writeback path */
`timescale 1ns/1ps

module cnfg_slave (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  cnfg_pkg::axil_m2s_t                    s_axil,
  output cnfg_pkg::axil_s2m_t                    s_axil_rsp,
  output cnfg_pkg::dma_req_t                     m_pr_dma,
  output logic                                   m_pr_dma_valid,
  input  logic                                   m_pr_dma_ready,
  input  logic                                   pr_dma_done,
  input  cnfg_pkg::wback_t                       s_wback,
  input  logic                                   s_wback_valid,
  output logic                                   s_wback_ready,
  output cnfg_pkg::dma_req_t                     m_wb_dma,
  output logic                                   m_wb_dma_valid,
  input  logic                                   m_wb_dma_ready,
  output logic [cnfg_pkg::WB_DATA_BITS-1:0]      m_axis_wb_tdata,
  output logic                                   m_axis_wb_tvalid,
  input  logic                                   m_axis_wb_tready,
  output logic [cnfg_pkg::LOWSPEED_OUT_BITS-1:0] lowspeed_ctrl
);

  cnfg_pkg::reg_wr_t                   reg_wr;
  logic                                reg_wr_en;
  logic [cnfg_pkg::REG_IDX_BITS-1:0]   rd_idx;
  logic [cnfg_pkg::AXIL_DATA_BITS-1:0] rd_data;  // Combinational lookup

  // --------------------------------------------------
  // Bus port and register file
  // --------------------------------------------------
  axil_ctrl_port port_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .s_axil     (s_axil),
    .s_axil_rsp (s_axil_rsp),
    .reg_wr     (reg_wr),
    .reg_wr_en  (reg_wr_en),
    .rd_idx     (rd_idx),
    .rd_data    (rd_data)
  );

  cnfg_regs regs_i (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .reg_wr         (reg_wr),
    .reg_wr_en      (reg_wr_en),
    .rd_idx         (rd_idx),
    .rd_data        (rd_data),
    .m_pr_dma       (m_pr_dma),
    .m_pr_dma_valid (m_pr_dma_valid),
    .m_pr_dma_ready (m_pr_dma_ready),
    .pr_dma_done    (pr_dma_done),
    .lowspeed_ctrl  (lowspeed_ctrl)
  );

  // Writeback
  wback_path wback_i (
    .aclk             (aclk),
    .aresetn          (aresetn),
    .s_wback          (s_wback),
    .s_wback_valid    (s_wback_valid),
    .s_wback_ready    (s_wback_ready),
    .m_wb_dma         (m_wb_dma),
    .m_wb_dma_valid   (m_wb_dma_valid),
    .m_wb_dma_ready   (m_wb_dma_ready),
    .m_axis_wb_tdata  (m_axis_wb_tdata),
    .m_axis_wb_tvalid (m_axis_wb_tvalid),
    .m_axis_wb_tready (m_axis_wb_tready)
  );

endmodule

// File: sim/tb_clk_gen.sv
/* Testbench clock and synchronous reset source */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS  = 8.0,
  parameter int  RST_CYCLES = 16
) (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2.0) aclk = ~aclk;
  end

  initial begin
    aresetn = 1'b0;
    repeat (RST_CYCLES) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;  // Released away from the active edge
  end

endmodule

// File: sim/cnfg_slave_tb.sv
/* Testbench for the host control-register block, bus tasks,
   register reference model, output comparison and watchdog */
`timescale 1ns/1ps

module cnfg_slave_tb;

  localparam int CLK_PERIOD_NS = 8;
  localparam int RST_CYCLES    = 16;
  localparam int PR_STARTS     = 18;  // Two more than the queue holds
  localparam int WB_ITEMS      = 40;
  localparam int TEST_CYCLES   = 2500;  // Rough budget of all phases with margin
  localparam int WATCHDOG_NS   = CLK_PERIOD_NS * TEST_CYCLES;

  logic aclk;
  logic aresetn;

  cnfg_pkg::axil_m2s_t s_axil;
  cnfg_pkg::axil_s2m_t s_axil_rsp;
  cnfg_pkg::dma_req_t  m_pr_dma;
  logic                m_pr_dma_valid;
  logic                m_pr_dma_ready;
  logic                pr_dma_done;
  cnfg_pkg::wback_t    s_wback;
  logic                s_wback_valid;
  logic                s_wback_ready;
  cnfg_pkg::dma_req_t  m_wb_dma;
  logic                m_wb_dma_valid;
  logic                m_wb_dma_ready;
  logic [31:0]         m_axis_wb_tdata;
  logic                m_axis_wb_tvalid;
  logic                m_axis_wb_tready;
  logic [2:0]          lowspeed_ctrl;

  integer seed = 32'h9dd2_b149;

  // Register model state
  logic [5:0]  lowspeed_m;
  logic [63:0] pr_addr_m;
  logic [31:0] pr_len_m;
  logic        done_m;
  int          pr_cnt;  // Entries held by the PR queue

  cnfg_pkg::dma_req_t exp_pr[$];
  cnfg_pkg::dma_req_t exp_wb[$];
  logic [31:0]        exp_val[$];

  tb_clk_gen #(
    .PERIOD_NS  (CLK_PERIOD_NS),
    .RST_CYCLES (RST_CYCLES)
  ) clk_gen_i (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  cnfg_slave dut_i (
    .aclk             (aclk),
    .aresetn          (aresetn),
    .s_axil           (s_axil),
    .s_axil_rsp       (s_axil_rsp),
    .m_pr_dma         (m_pr_dma),
    .m_pr_dma_valid   (m_pr_dma_valid),
    .m_pr_dma_ready   (m_pr_dma_ready),
    .pr_dma_done      (pr_dma_done),
    .s_wback          (s_wback),
    .s_wback_valid    (s_wback_valid),
    .s_wback_ready    (s_wback_ready),
    .m_wb_dma         (m_wb_dma),
    .m_wb_dma_valid   (m_wb_dma_valid),
    .m_wb_dma_ready   (m_wb_dma_ready),
    .m_axis_wb_tdata  (m_axis_wb_tdata),
    .m_axis_wb_tvalid (m_axis_wb_tvalid),
    .m_axis_wb_tready (m_axis_wb_tready),
    .lowspeed_ctrl    (lowspeed_ctrl)
  );

  // --------------------------------------------------
  // Failure reporting
  // --------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
    $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    stop_run("Value mismatch");
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [63:0] ref_read(input logic [6:0] idx);
    logic [63:0] r;
    r = '0;
    case (idx)
      7'd0:  r[31:0] = cnfg_pkg::PROBE_ID;
      7'd1:  r = 64'd4;
      7'd8:  r[5:0] = lowspeed_m;
      7'd11: r[1:0] = {pr_cnt < 16, done_m};  // Queue ready, done
      7'd12: r = pr_addr_m;
      7'd13: r[31:0] = pr_len_m;
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic model_write(input logic [6:0] idx, input logic [63:0] data,
                             input logic [7:0] strb);
    cnfg_pkg::dma_req_t req;
    for (int i = 0; i < 8; i++) begin
      if (strb[i] && idx == 7'd12) pr_addr_m[i*8 +: 8] = data[i*8 +: 8];
      if (strb[i] && idx == 7'd13 && i < 4) pr_len_m[i*8 +: 8] = data[i*8 +: 8];
    end
    if (idx == 7'd8 && strb[0]) lowspeed_m = data[5:0];
    if (idx == 7'd10 && strb[0]) begin
      if (data[2]) done_m = 1'b0;
      if (data[0] && pr_cnt < 16) begin  // Starts into a full queue are lost
        req.ctl   = data[1];
        req.paddr = pr_addr_m[47:0];
        req.len   = pr_len_m[27:0];
        exp_pr.push_back(req);
        pr_cnt++;
      end
    end
  endtask

  // --------------------------------------------------
  // AXI4-Lite tasks, driven on the falling edge
  // --------------------------------------------------
  task automatic axil_write(input logic [6:0] idx, input logic [63:0] data,
                            input logic [7:0] strb, input int hold);
    int n;
    s_axil.awaddr  = {idx, 3'b000};
    s_axil.wdata   = data;
    s_axil.wstrb   = strb;
    s_axil.awvalid = 1'b1;
    s_axil.wvalid  = 1'b1;
    n = 0;
    do begin
      @(negedge aclk);
      n++;
    end while (!s_axil_rsp.awready);
    assert (n == 1 && s_axil_rsp.wready)
      else stop_run("Write was not accepted one cycle after the valids");
    @(negedge aclk);
    s_axil.awvalid = 1'b0;
    s_axil.wvalid  = 1'b0;
    assert (s_axil_rsp.bvalid && s_axil_rsp.bresp == 2'b00)
      else stop_run("Write response missing after the write handshake");
    model_write(idx, data, strb);
    // Same write offered again while the response waits
    s_axil.awvalid = (hold > 0);
    s_axil.wvalid  = (hold > 0);
    for (int i = 0; i < hold; i++) begin
      @(negedge aclk);
      assert (s_axil_rsp.bvalid && !s_axil_rsp.awready && !s_axil_rsp.wready)
        else stop_run("Write response dropped or second write accepted early");
    end
    s_axil.awvalid = 1'b0;
    s_axil.wvalid  = 1'b0;
    s_axil.bready  = 1'b1;
    @(negedge aclk);
    s_axil.bready = 1'b0;
    assert (!s_axil_rsp.bvalid) else stop_run("bvalid stayed high after bready");
  endtask

  task automatic axil_read(input logic [6:0] idx, input int hold,
                           output logic [63:0] data);
    int n;
    s_axil.araddr  = {idx, 3'b000};
    s_axil.arvalid = 1'b1;
    n = 0;
    do begin
      @(negedge aclk);
      n++;
    end while (!s_axil_rsp.arready);
    assert (n == 1) else stop_run("arready did not follow arvalid by one cycle");
    @(negedge aclk);
    s_axil.arvalid = 1'b0;
    assert (s_axil_rsp.rvalid && s_axil_rsp.rresp == 2'b00)
      else stop_run("rvalid did not follow arready by one cycle");
    data = s_axil_rsp.rdata;
    s_axil.arvalid = (hold > 0);
    for (int i = 0; i < hold; i++) begin
      @(negedge aclk);
      assert (s_axil_rsp.rvalid && !s_axil_rsp.arready)
        else stop_run("Read response dropped or second read accepted early");
      assert (s_axil_rsp.rdata == data)
        else value_mismatch("rdata", 128'(s_axil_rsp.rdata), 128'(data));
    end
    s_axil.arvalid = 1'b0;
    s_axil.rready  = 1'b1;
    @(negedge aclk);
    s_axil.rready = 1'b0;
    assert (!s_axil_rsp.rvalid) else stop_run("rvalid stayed high after rready");
  endtask

  task automatic check_read(input logic [6:0] idx, input int hold);
    logic [63:0] got;
    logic [63:0] exp;
    axil_read(idx, hold, got);
    exp = ref_read(idx);
    assert (got == exp) else value_mismatch("rdata", 128'(got), 128'(exp));
  endtask

  // One cycle with fresh random back-pressure on the writeback outputs
  task automatic step_with_backpressure();
    @(negedge aclk);
    m_wb_dma_ready   = 1'($random(seed));
    m_axis_wb_tready = 1'($random(seed));
  endtask

  // --------------------------------------------------
  // Output comparison
  // --------------------------------------------------
  always @(posedge aclk) begin
    if (aresetn) begin
      if (m_pr_dma_valid && m_pr_dma_ready) begin
        assert (exp_pr.size() > 0) else stop_run("Unexpected PR DMA request");
        assert (m_pr_dma == exp_pr[0])
          else value_mismatch("m_pr_dma", 128'(m_pr_dma), 128'(exp_pr[0]));
        void'(exp_pr.pop_front());
        pr_cnt--;
      end
      if (m_wb_dma_valid && m_wb_dma_ready) begin
        assert (exp_wb.size() > 0) else stop_run("Unexpected writeback DMA request");
        assert (m_wb_dma == exp_wb[0])
          else value_mismatch("m_wb_dma", 128'(m_wb_dma), 128'(exp_wb[0]));
        void'(exp_wb.pop_front());
      end
      if (m_axis_wb_tvalid && m_axis_wb_tready) begin
        assert (exp_val.size() > 0) else stop_run("Unexpected writeback stream value");
        assert (m_axis_wb_tdata == exp_val[0])
          else value_mismatch("m_axis_wb_tdata", 128'(m_axis_wb_tdata), 128'(exp_val[0]));
        void'(exp_val.pop_front());
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    stop_run("Timeout, the run did not finish in time");
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    cnfg_pkg::wback_t item;
    cnfg_pkg::dma_req_t req;
    logic [63:0] d;
    s_axil           = '0;
    m_pr_dma_ready   = 1'b1;
    pr_dma_done      = 1'b0;
    s_wback          = '0;
    s_wback_valid    = 1'b0;
    m_wb_dma_ready   = 1'b1;
    m_axis_wb_tready = 1'b1;
    lowspeed_m       = 6'h3f;
    pr_addr_m        = '0;
    pr_len_m         = '0;
    done_m           = 1'b0;
    pr_cnt           = 0;

    wait (aresetn);
    @(negedge aclk);
    assert (!s_axil_rsp.awready && !s_axil_rsp.wready && !s_axil_rsp.bvalid &&
            !s_axil_rsp.arready && !s_axil_rsp.rvalid && !m_pr_dma_valid &&
            !m_wb_dma_valid && !m_axis_wb_tvalid)
      else stop_run("Outputs not low after reset");

    // Configuration words and unmapped space
    check_read(7'd0, 0);
    check_read(7'd1, 0);
    check_read(7'h55, 0);
    check_read(7'd10, 0);

    // Low-speed control
    check_read(7'd8, 0);
    assert (lowspeed_ctrl == 3'h7)
      else value_mismatch("lowspeed_ctrl", 128'(lowspeed_ctrl), 128'(3'h7));
    for (int k = 0; k < 8; k++) begin
      d = {$random(seed), $random(seed)};
      axil_write(7'd8, d, 8'($random(seed)), 0);
      check_read(7'd8, 0);
      assert (lowspeed_ctrl == lowspeed_m[2:0])
        else value_mismatch("lowspeed_ctrl", 128'(lowspeed_ctrl), 128'(lowspeed_m[2:0]));
    end

    // PR requests held back, then drained in order
    m_pr_dma_ready = 1'b0;
    for (int k = 0; k < PR_STARTS; k++) begin
      axil_write(7'd12, {$random(seed), $random(seed)}, 8'hff, 0);
      axil_write(7'd13, {32'h0, $random(seed)}, 8'h0f, 0);
      axil_write(7'd10, {62'h0, 1'($random(seed)), 1'b1}, 8'h01, 0);
      if (k == 15 || k == PR_STARTS - 1) begin
        check_read(7'd11, 0);
      end
    end
    check_read(7'd12, 0);
    check_read(7'd13, 0);
    m_pr_dma_ready = 1'b1;
    while (exp_pr.size() != 0) @(negedge aclk);
    @(negedge aclk);
    check_read(7'd11, 0);

    // Done flag set by the engine, cleared by the host
    pr_dma_done = 1'b1;
    @(negedge aclk);
    pr_dma_done = 1'b0;
    done_m      = 1'b1;
    check_read(7'd11, 0);
    axil_write(7'd10, 64'h4, 8'h01, 0);
    check_read(7'd11, 0);

    // Writeback under random back-pressure
    for (int k = 0; k < WB_ITEMS; k++) begin
      item.paddr = 48'({$random(seed), $random(seed)});
      item.value = $random(seed);
      s_wback       = item;
      s_wback_valid = 1'b1;
      while (!s_wback_ready) step_with_backpressure();
      req.ctl   = 1'b1;
      req.paddr = item.paddr;
      req.len   = 28'd4;
      exp_wb.push_back(req);
      exp_val.push_back(item.value);
      step_with_backpressure();
      s_wback_valid = 1'b0;
      if ($random(seed) % 4 == 0) step_with_backpressure();
    end
    m_wb_dma_ready   = 1'b1;
    m_axis_wb_tready = 1'b1;
    while (exp_wb.size() != 0 || exp_val.size() != 0) @(negedge aclk);
    @(negedge aclk);

    // Responses held under a stalled master
    for (int k = 0; k < 4; k++) begin
      axil_write(7'd8, {$random(seed), $random(seed)}, 8'h01,
                 2 + ($unsigned($random(seed)) % 6));
      check_read(7'd8, 2 + ($unsigned($random(seed)) % 6));
      check_read(7'd0, 1 + ($unsigned($random(seed)) % 4));
    end

    repeat (4) @(negedge aclk);
    $display("Verification passed");
    $finish;
  end

endmodule

// File: cnfg_slave.f
logic/cnfg_pkg.sv
logic/req_queue.sv
logic/axil_ctrl_port.sv
logic/cnfg_regs.sv
logic/wback_path.sv
logic/cnfg_slave.sv
sim/tb_clk_gen.sv
sim/cnfg_slave_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cnfg_slave_tb
FILELIST  ?= cnfg_slave.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
